// File: compile.f
verilog/eeprom_pkg.sv
verilog/eeprom_txn_decode.sv
verilog/eeprom_bit_engine.sv
verilog/eeprom_read_result.sv
verilog/eeprom_ctrl.sv
dv/clk_gen.sv
dv/eeprom_model.sv
dv/eeprom_ctrl_properties.sv
dv/tb_eeprom_ctrl.sv

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = !CLK; // 40 ns period
    end

    initial
    begin
        RESET = 1'b1;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
    end

endmodule

// File: dv/eeprom_ctrl_properties.sv
`timescale 1ns/1ps

module eeprom_ctrl_properties
(
    input logic              CLK,
    input logic              RESET,
    input logic              busy,
    input eeprom_pkg::step_t kind_q,
    input logic [1:0]        phase,
    input logic              sda_out,
    input logic              sda_oe,
    input logic              step_go,
    input logic              step_done
);

    logic in_step; // from step_go until step_done

    always_ff @(posedge CLK)
    begin
        if (RESET)
            in_step <= 1'b0;
        else if (step_go)
            in_step <= 1'b1;
        else if (step_done)
            in_step <= 1'b0;
    end

    // data bit held across both scl-high phases
    assert property (@(posedge CLK) disable iff (RESET)
        busy && kind_q == eeprom_pkg::step_send && phase == 2'd2 |=> $stable(sda_out))
        else $error("sda changed while scl high in a send step");

    assert property (@(posedge CLK) disable iff (RESET) step_done |=> !step_done)
        else $error("step_done high for two cycles");

    assert property (@(posedge CLK) disable iff (RESET) !in_step |-> !sda_oe)
        else $error("sda driven outside a step");

endmodule

bind eeprom_bit_engine eeprom_ctrl_properties props_i
(
    .CLK       (CLK),
    .RESET     (RESET),
    .busy      (busy),
    .kind_q    (kind_q),
    .phase     (phase),
    .sda_out   (sda_out),
    .sda_oe    (sda_oe),
    .step_go   (step_go),
    .step_done (step_done)
);

// File: dv/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    output logic drv_en,
    output logic drv_val
);

    localparam int mem_size = 2048;

    typedef enum logic [2:0]
    {
        m_idle,
        m_ctrl,
        m_word,
        m_data,
        m_tx,
        m_wait
    } model_state_t;

    eeprom_pkg::byte_t      mem [0:mem_size-1];
    model_state_t           state;
    eeprom_pkg::word_addr_t ptr;
    eeprom_pkg::byte_t      shift;
    eeprom_pkg::byte_t      tx;
    logic [3:0]             cnt;
    logic                   in_ack;
    logic                   prev_scl;
    logic                   prev_sda;
    logic                   rx_state;

    initial
    begin
        // pattern mixes page and low address bits
        for (int i = 0; i < mem_size; i++)
            mem[i] = 8'(i) ^ (8'(i >> 8) * 8'h35);
        state    = m_idle;
        ptr      = '0;
        shift    = '0;
        tx       = '0;
        cnt      = '0;
        in_ack   = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        drv_en   = 1'b0;
        drv_val  = 1'b1;
    end

    // bus oversampled on the falling CLK edge
    always @(negedge CLK)
    begin
        rx_state = (state == m_ctrl) || (state == m_word) || (state == m_data);
        if (prev_scl && scl && prev_sda && !sda)
        begin
            state  = m_ctrl; // start or repeated start
            cnt    = '0;
            in_ack = 1'b0;
            drv_en = 1'b0;
        end
        else if (prev_scl && scl && !prev_sda && sda)
        begin
            state  = m_idle; // stop
            in_ack = 1'b0;
            drv_en = 1'b0;
        end
        else if (!prev_scl && scl)
        begin
            if (rx_state && !in_ack && cnt < 4'd8)
            begin
                shift = {shift[6:0], sda};
                cnt   = cnt + 4'd1;
            end
        end
        else if (prev_scl && !scl)
        begin
            if (in_ack)
            begin
                in_ack = 1'b0;
                drv_en = 1'b0;
                cnt    = '0;
                case (state)
                    m_ctrl:
                    begin
                        if (shift[7:4] != eeprom_pkg::device_code)
                            state = m_idle;
                        else
                        begin
                            ptr[10:8] = shift[3:1];
                            if (shift[0])
                            begin
                                state   = m_tx;
                                tx      = mem[ptr];
                                drv_en  = 1'b1;
                                drv_val = tx[7];
                                tx      = {tx[6:0], 1'b0};
                                cnt     = 4'd1;
                            end
                            else
                                state = m_word;
                        end
                    end
                    m_word:
                    begin
                        ptr[7:0] = shift;
                        state    = m_data;
                    end
                    default:
                    begin
                        mem[ptr] = shift;
                        state    = m_wait;
                    end
                endcase
            end
            else if (rx_state && cnt == 4'd8)
            begin
                in_ack  = 1'b1; // ack every byte
                drv_en  = 1'b1;
                drv_val = 1'b0;
            end
            else if (state == m_tx)
            begin
                if (cnt < 4'd8)
                begin
                    drv_val = tx[7];
                    tx      = {tx[6:0], 1'b0};
                    cnt     = cnt + 4'd1;
                end
                else
                begin
                    drv_en = 1'b0; // master nacks, then stops
                    state  = m_wait;
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

// File: dv/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    localparam int n_ops = 16;
    localparam int ack_timeout = 2000;
    localparam int reset_timeout = 20;

    logic                   CLK;
    logic                   RESET;
    logic                   wr;
    logic                   rd;
    eeprom_pkg::word_addr_t addr;
    eeprom_pkg::byte_t      wr_data;
    logic                   sda_in;
    eeprom_pkg::byte_t      rd_data;
    logic                   ack;
    logic                   scl;
    logic                   sda_out;
    logic                   sda_oe;
    logic                   model_oe;
    logic                   model_val;

    // stimulus table: op 1 = read
    logic                   op_tab   [n_ops];
    eeprom_pkg::word_addr_t addr_tab [n_ops];
    eeprom_pkg::byte_t      data_tab [n_ops];
    eeprom_pkg::byte_t      exp_tab  [n_ops];
    logic                   busy_tab [n_ops];

    eeprom_pkg::byte_t      exp_mem [int];
    eeprom_pkg::byte_t      run_mem [int];
    eeprom_pkg::byte_t      last_read;
    eeprom_pkg::word_addr_t busy_addr;
    logic [31:0]            lcg_state;
    int                     ack_count;

    clk_gen clk_gen_i (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl eeprom_ctrl_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_in),
        .rd_data (rd_data),
        .ack     (ack),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

    eeprom_model model_i
    (
        .CLK     (CLK),
        .scl     (scl),
        .sda     (sda_in),
        .drv_en  (model_oe),
        .drv_val (model_val)
    );

    assign sda_in = sda_oe ? sda_out : (model_oe ? model_val : 1'b1); // pull-up

    always @(negedge CLK)
    begin
        if (ack)
            ack_count <= ack_count + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_memory();
        foreach (run_mem[a])
            check("model mem", 16'(model_i.mem[a]), 16'(run_mem[a]));
    endtask

    task automatic run_op(input int i);
        int start_count;
        int cycles;
        start_count = ack_count;
        cycles = 0;
        addr    = addr_tab[i];
        wr_data = data_tab[i];
        wr      = !op_tab[i];
        rd      = op_tab[i];
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (!ack)
        begin
            cycles++;
            if (cycles > ack_timeout)
            begin
                $display("Error: no ack within %0d cycles for table entry %0d", ack_timeout, i);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            if (busy_tab[i] && cycles == 30)
            begin
                addr    = busy_addr; // must be ignored
                wr_data = 8'hc3;
                wr      = 1'b1;
            end
            else
                wr = 1'b0;
            @(negedge CLK);
        end
        wr = 1'b0;
        check("scl", 16'(scl), 16'd1); // bus parked after stop
        check("sda_oe", 16'(sda_oe), 16'd0);
        if (op_tab[i])
        begin
            check("rd_data", 16'(rd_data), 16'(exp_tab[i]));
            last_read = exp_tab[i];
        end
        else
        begin
            run_mem[addr_tab[i]] = data_tab[i];
            check("rd_data", 16'(rd_data), 16'(last_read)); // held across writes
        end
        repeat (busy_tab[i] ? 250 : 10) @(negedge CLK);
        check("ack count", 16'(ack_count - start_count), 16'd1);
        check_memory();
    endtask

    initial
    begin
        int reset_cycles;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        ack_count = 0;
        last_read = '0;
        busy_addr = 11'h5aa;
        lcg_state = 32'd29646;

        reset_cycles = 0;
        while (RESET !== 1'b0)
        begin
            if (reset_cycles > reset_timeout)
            begin
                $display("Error: reset was not released within %0d cycles", reset_timeout);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            @(posedge CLK);
            reset_cycles++;
        end
        repeat (8)
        begin
            @(negedge CLK);
            check("scl", 16'(scl), 16'd1);
            check("sda_oe", 16'(sda_oe), 16'd0);
            check("ack", 16'(ack), 16'd0);
            check("rd_data", 16'(rd_data), 16'd0);
        end

        addr_tab = '{11'h012, 11'h112, 11'h212, 11'h712, 11'h3ff, 11'h000,
                     11'h012, 11'h112, 11'h212, 11'h712, 11'h3ff, 11'h000,
                     11'h5aa, 11'h212, 11'h712, 11'h100};
        op_tab   = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 0, 1, 0};
        for (int i = 0; i < n_ops; i++)
        begin
            busy_tab[i] = (i == 4);
            exp_mem[addr_tab[i]] = model_i.mem[addr_tab[i]];
        end
        exp_mem[busy_addr] = model_i.mem[busy_addr];
        run_mem = exp_mem;

        for (int i = 0; i < n_ops; i++)
        begin
            lcg_state   = lcg_next(lcg_state);
            data_tab[i] = lcg_state[23:16];
            exp_tab[i]  = exp_mem[addr_tab[i]];
            if (!op_tab[i])
                exp_mem[addr_tab[i]] = data_tab[i];
        end

        for (int i = 0; i < n_ops; i++)
            run_op(i);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the eeprom_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_eeprom_ctrl -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: verilog/eeprom_bit_engine.sv
`timescale 1ns/1ps

module eeprom_bit_engine
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              step_go,
    input  eeprom_pkg::step_t step_kind,
    input  eeprom_pkg::byte_t step_byte,
    input  logic              sda_in,
    output logic              step_done,
    output logic              bit_strobe,
    output logic              bit_value,
    output logic              scl,
    output logic              sda_out,
    output logic              sda_oe
);

    localparam int last_phase = eeprom_pkg::phases_per_bit - 1;
    localparam int last_slot  = eeprom_pkg::bits_per_byte_slot - 1;
    localparam int data_bits  = $bits(eeprom_pkg::byte_t);

    logic                              busy;
    logic                              idle_scl; // scl level between steps
    eeprom_pkg::step_t                 kind_q;
    logic [eeprom_pkg::phase_w-1:0]    phase;
    logic [eeprom_pkg::slot_cnt_w-1:0] bit_cnt;
    eeprom_pkg::byte_t                 shreg;
    logic                              phase_end;
    logic                              scl_high;
    logic                              data_slot;
    logic                              single_bit;

    assign phase_end  = (phase == eeprom_pkg::phase_w'(last_phase));
    assign scl_high   = (phase >= eeprom_pkg::phase_w'(eeprom_pkg::phases_per_bit / 2));
    assign data_slot  = (bit_cnt < eeprom_pkg::slot_cnt_w'(data_bits));
    assign single_bit = (kind_q == eeprom_pkg::step_start) || (kind_q == eeprom_pkg::step_stop);

    assign step_done = busy && phase_end &&
                       (single_bit || bit_cnt == eeprom_pkg::slot_cnt_w'(last_slot));

    // first scl-high phase of each received data bit
    assign bit_strobe = busy && kind_q == eeprom_pkg::step_recv && data_slot &&
                        phase == eeprom_pkg::phase_w'(eeprom_pkg::phases_per_bit / 2);
    assign bit_value  = sda_in;

    assign scl = busy ? scl_high : idle_scl;

    always_comb
    begin
        sda_oe  = 1'b0;
        sda_out = 1'b1;
        if (busy)
        begin
            case (kind_q)
                eeprom_pkg::step_start:
                begin
                    sda_oe  = 1'b1;
                    sda_out = !phase_end; // falls while scl high
                end
                eeprom_pkg::step_stop:
                begin
                    sda_oe  = 1'b1;
                    sda_out = phase_end;  // rises while scl high
                end
                eeprom_pkg::step_send:
                begin
                    sda_oe  = data_slot;  // released for slave ack
                    sda_out = shreg[7];
                end
                default:
                begin
                    sda_oe  = !data_slot; // master nack, sda high
                    sda_out = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            idle_scl <= 1'b1;
            phase    <= '0;
            bit_cnt  <= '0;
        end
        else if (!busy)
        begin
            if (step_go)
            begin
                busy    <= 1'b1;
                phase   <= '0;
                bit_cnt <= '0;
            end
        end
        else
        begin
            phase <= phase + 1'b1;
            if (step_done)
            begin
                busy     <= 1'b0;
                // park scl high only once the bus is stopped
                idle_scl <= (kind_q == eeprom_pkg::step_stop);
            end
            else if (phase_end)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // step payload, msb goes out first
    always_ff @(posedge CLK)
    begin
        if (!busy && step_go)
        begin
            kind_q <= step_kind;
            shreg  <= step_byte;
        end
        else if (busy && phase_end)
            shreg <= {shreg[6:0], 1'b0};
    end

endmodule

// File: verilog/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  eeprom_pkg::word_addr_t addr,
    input  eeprom_pkg::byte_t      wr_data,
    input  logic                   sda_in,
    output eeprom_pkg::byte_t      rd_data,
    output logic                   ack,
    output logic                   scl,
    output logic                   sda_out,
    output logic                   sda_oe
);

    logic              step_go;
    logic              step_done;
    eeprom_pkg::step_t step_kind;
    eeprom_pkg::byte_t step_byte;
    logic              txn_done;
    logic              bit_strobe;
    logic              bit_value;

    eeprom_txn_decode decode_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .step_done (step_done),
        .step_go   (step_go),
        .step_kind (step_kind),
        .step_byte (step_byte),
        .txn_done  (txn_done)
    );

    eeprom_bit_engine engine_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .step_go    (step_go),
        .step_kind  (step_kind),
        .step_byte  (step_byte),
        .sda_in     (sda_in),
        .step_done  (step_done),
        .bit_strobe (bit_strobe),
        .bit_value  (bit_value),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

    eeprom_read_result result_i
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .bit_strobe (bit_strobe),
        .bit_value  (bit_value),
        .txn_done   (txn_done),
        .rd_data    (rd_data),
        .ack        (ack)
    );

endmodule

// File: verilog/eeprom_pkg.sv
package eeprom_pkg;

    // device select nibble of every control byte
    localparam logic [3:0] device_code = 4'b1010;

    // CLK cycles per SCL period
    localparam int phases_per_bit = 4;

    // 8 data bits plus the acknowledge clock
    localparam int bits_per_byte_slot = 9;

    localparam int phase_w = $clog2(phases_per_bit);
    localparam int slot_cnt_w = $clog2(bits_per_byte_slot);

    typedef logic [7:0] byte_t;

    // bits 10:8 go out as page bits in the control byte
    typedef logic [10:0] word_addr_t;

    // one operation on the wire
    typedef enum logic [1:0]
    {
        step_start,
        step_send,
        step_recv,
        step_stop
    } step_t;

    typedef enum logic [3:0]
    {
        idle,
        start,
        ctrl_wr,
        word,
        data_wr,
        restart,
        ctrl_rd,
        data_rd,
        stop,
        done
    } txn_state_t;

endpackage

// File: verilog/eeprom_read_result.sv
`timescale 1ns/1ps

module eeprom_read_result
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              bit_strobe,
    input  logic              bit_value,
    input  logic              txn_done,
    output eeprom_pkg::byte_t rd_data,
    output logic              ack
);

    localparam int data_bits = $bits(eeprom_pkg::byte_t);

    eeprom_pkg::byte_t                 shreg;
    logic [eeprom_pkg::slot_cnt_w-1:0] rx_cnt; // bits since last txn_done

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rx_cnt  <= '0;
            ack     <= 1'b0;
            rd_data <= '0;
        end
        else
        begin
            ack <= txn_done;
            if (txn_done)
            begin
                // a full byte means this was a read
                if (rx_cnt == eeprom_pkg::slot_cnt_w'(data_bits))
                    rd_data <= shreg;
                rx_cnt <= '0;
            end
            else if (bit_strobe)
                rx_cnt <= rx_cnt + 1'b1;
        end
    end

    // msb first
    always_ff @(posedge CLK)
    begin
        if (bit_strobe)
            shreg <= {shreg[6:0], bit_value};
    end

endmodule

// File: verilog/eeprom_txn_decode.sv
`timescale 1ns/1ps

module eeprom_txn_decode
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  eeprom_pkg::word_addr_t addr,
    input  eeprom_pkg::byte_t      wr_data,
    input  logic                   step_done,
    output logic                   step_go,
    output eeprom_pkg::step_t      step_kind,
    output eeprom_pkg::byte_t      step_byte,
    output logic                   txn_done
);

    eeprom_pkg::txn_state_t state;
    eeprom_pkg::txn_state_t nxt_state;
    eeprom_pkg::step_t      nxt_kind;
    eeprom_pkg::byte_t      nxt_byte;
    eeprom_pkg::word_addr_t addr_q;
    eeprom_pkg::byte_t      data_q;
    logic                   is_read;

    // what comes after the step that is running now
    always_comb
    begin
        nxt_state = state;
        nxt_kind  = eeprom_pkg::step_send;
        nxt_byte  = addr_q[7:0];
        case (state)
            eeprom_pkg::start:
            begin
                nxt_state = eeprom_pkg::ctrl_wr;
                nxt_byte  = {eeprom_pkg::device_code, addr_q[10:8], 1'b0};
            end
            eeprom_pkg::ctrl_wr: nxt_state = eeprom_pkg::word;
            eeprom_pkg::word:
            begin
                if (is_read)
                begin
                    nxt_state = eeprom_pkg::restart;
                    nxt_kind  = eeprom_pkg::step_start;
                end
                else
                begin
                    nxt_state = eeprom_pkg::data_wr;
                    nxt_byte  = data_q;
                end
            end
            eeprom_pkg::restart:
            begin
                nxt_state = eeprom_pkg::ctrl_rd;
                nxt_byte  = {eeprom_pkg::device_code, addr_q[10:8], 1'b1}; // r/w = 1
            end
            eeprom_pkg::ctrl_rd:
            begin
                nxt_state = eeprom_pkg::data_rd;
                nxt_kind  = eeprom_pkg::step_recv;
            end
            eeprom_pkg::data_wr,
            eeprom_pkg::data_rd:
            begin
                nxt_state = eeprom_pkg::stop;
                nxt_kind  = eeprom_pkg::step_stop;
            end
            eeprom_pkg::stop: nxt_state = eeprom_pkg::done;
            default: nxt_state = eeprom_pkg::idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::idle;
            step_go  <= 1'b0;
            txn_done <= 1'b0;
            is_read  <= 1'b0;
        end
        else
        begin
            step_go  <= 1'b0;
            txn_done <= 1'b0;
            case (state)
                eeprom_pkg::idle:
                begin
                    if (wr || rd)
                    begin
                        is_read <= !wr; // wr wins
                        state   <= eeprom_pkg::start;
                        step_go <= 1'b1;
                    end
                end
                eeprom_pkg::done: state <= eeprom_pkg::idle;
                default:
                begin
                    if (step_done)
                    begin
                        state <= nxt_state;
                        if (state == eeprom_pkg::stop)
                            txn_done <= 1'b1;
                        else
                            step_go <= 1'b1;
                    end
                end
            endcase
        end
    end

    // request payload and step arguments
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::idle && (wr || rd))
        begin
            addr_q    <= addr;
            data_q    <= wr_data;
            step_kind <= eeprom_pkg::step_start;
            step_byte <= '1;
        end
        else if (step_done)
        begin
            step_kind <= nxt_kind;
            step_byte <= nxt_byte;
        end
    end

endmodule
